/* bus_pkg.sv */
/* Shared widths and encodings for the two-core bus. Addresses are word addresses
   and the grant is one bit, so only two cores are supported */
package bus_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int RUN_CNT_W = 8;
    localparam int LAT_CNT_W = 4;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [RUN_CNT_W-1:0] run_cnt_t;
    typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

    // Index of the core that owns the memory port
    typedef logic grant_t;

    // Pipeline state reported by a core. A switch is only safe at cs_id
    typedef enum logic [3:0] {
        cs_if  = 4'd0,
        cs_id  = 4'd1,
        cs_ex  = 4'd2,
        cs_mem = 4'd3,
        cs_wb  = 4'd4
    } cpustate_t;

    // Slice machine of the arbiter
    typedef enum logic [1:0] {
        arb_wait   = 2'd0,
        arb_switch = 2'd1,
        arb_settle = 2'd2,
        arb_run    = 2'd3
    } arb_state_t;

endpackage

/* core_bus_if.sv */
/* Bus signals of one core. Strobes are single-cycle and may only be raised
   while busy is low */
interface core_bus_if;
    import bus_pkg::*;

    addr_t     paddr;
    logic      we;
    logic      le;
    data_t     wdata;
    cpustate_t cpustate;
    data_t     rdata;
    logic      busy;

    // Core side drives the request and its pipeline state
    modport core (
        output paddr,
        output we,
        output le,
        output wdata,
        output cpustate,
        input  rdata,
        input  busy
    );

    modport arb (
        input  paddr,
        input  we,
        input  le,
        input  wdata,
        input  cpustate,
        output rdata,
        output busy
    );

endinterface

/* mem_bus_if.sv */
/* Arbiter to memory link with the plain strobe-and-busy convention,
   no handshake beyond the busy level */
interface mem_bus_if;
    import bus_pkg::*;

    addr_t addr;
    logic  we;
    logic  le;
    data_t wdata;
    data_t rdata;
    logic  busy;

    modport master (
        output addr,
        output we,
        output le,
        output wdata,
        input  rdata,
        input  busy
    );

    modport slave (
        input  addr,
        input  we,
        input  le,
        input  wdata,
        output rdata,
        output busy
    );

endinterface

/* bus_arbiter_ser.sv */
/* Time-slice arbiter for exactly two cores. A switch needs the granted core at cs_id
   and the new owner keeps the bus for at least RUN_CYCLES plus one cycles */
module bus_arbiter_ser #(
    parameter int RUN_CYCLES = 2
) (
    input  logic            CLK,
    input  logic            RST_X,
    input  logic            init_done,
    core_bus_if.arb         core0,
    core_bus_if.arb         core1,
    mem_bus_if.master       mem,
    output bus_pkg::grant_t grant
);
    import bus_pkg::*;

    localparam run_cnt_t RUN_LAST = run_cnt_t'(RUN_CYCLES);

    arb_state_t state;
    run_cnt_t   cnt;
    grant_t     grant_q;
    cpustate_t  cur_cpustate;
    logic       no_req;
    logic       arb_busy;

    assign grant = grant_q;

    // Only the owner's pipeline state can end its slice
    assign cur_cpustate = (grant_q == 1'b0) ? core0.cpustate : core1.cpustate;
    assign no_req       = (cur_cpustate == cs_id);

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state   <= arb_wait;
            grant_q <= 1'b0;
            cnt     <= '0;
        end else if (init_done) begin
            case (state)
                arb_wait: begin
                    if (no_req) begin
                        state <= arb_switch;
                    end
                end
                arb_switch: begin
                    // Old owner still sees busy on this edge
                    grant_q <= ~grant_q;
                    state   <= arb_settle;
                end
                arb_settle: begin
                    cnt   <= '0;
                    state <= arb_run;
                end
                arb_run: begin
                    if (cnt < RUN_LAST) begin
                        cnt <= cnt + run_cnt_t'(1);
                    end else begin
                        state <= arb_wait;
                    end
                end
                default: begin
                    state <= arb_wait;
                end
            endcase
        end
    end

    // Busy is held high around the grant change so no access straddles it
    always_comb begin
        case (state)
            arb_switch: arb_busy = 1'b1;
            arb_settle: arb_busy = 1'b1;
            default:    arb_busy = mem.busy;
        endcase
    end

    // The ungranted core sees a busy bus and no data
    always_comb begin
        if (grant_q == 1'b0) begin
            core0.rdata = mem.rdata;
            core0.busy  = arb_busy;
            core1.rdata = '0;
            core1.busy  = 1'b1;
        end else begin
            core1.rdata = mem.rdata;
            core1.busy  = arb_busy;
            core0.rdata = '0;
            core0.busy  = 1'b1;
        end
    end

    always_comb begin
        if (grant_q == 1'b0) begin
            mem.addr  = core0.paddr;
            mem.we    = core0.we;
            mem.le    = core0.le;
            mem.wdata = core0.wdata;
        end else begin
            mem.addr  = core1.paddr;
            mem.we    = core1.we;
            mem.le    = core1.le;
            mem.wdata = core1.wdata;
        end
    end

endmodule

/* shared_mem.sv */
/* Word memory of 2**MEM_AW entries indexed by the low address bits. Strobes seen
   while busy is high are dropped, and load data is held until the next load ends */
module shared_mem #(
    parameter int MEM_LATENCY = 3,
    parameter int MEM_AW      = 6
) (
    input  logic      CLK,
    input  logic      RST_X,
    mem_bus_if.slave  bus
);
    import bus_pkg::*;

    localparam lat_cnt_t LAT = lat_cnt_t'(MEM_LATENCY);

    data_t             mem_q [2**MEM_AW];
    data_t             rdata_q;
    logic [MEM_AW-1:0] ld_addr;
    logic              ld_pend;
    lat_cnt_t          lat_cnt;
    logic              accept;

    assign bus.busy  = (lat_cnt != '0);
    assign bus.rdata = rdata_q;
    assign accept    = (bus.we || bus.le) && !bus.busy;

    // Busy counter and load bookkeeping
    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            lat_cnt <= '0;
            ld_pend <= 1'b0;
        end else if (accept) begin
            lat_cnt <= LAT;
            ld_pend <= bus.le;
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - lat_cnt_t'(1);
            if (lat_cnt == lat_cnt_t'(1)) begin
                ld_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept && bus.we) begin
            // Writes land on the strobe edge
            mem_q[bus.addr[MEM_AW-1:0]] <= bus.wdata;
        end
        if (accept && bus.le) begin
            ld_addr <= bus.addr[MEM_AW-1:0];
        end
        // Read word appears on the same edge that busy falls
        if (ld_pend && lat_cnt == lat_cnt_t'(1)) begin
            rdata_q <= mem_q[ld_addr];
        end
    end

endmodule

/* dual_core_bus_top.sv */
/* Two cores sharing one memory port through the time-slice arbiter.
   Core 1 reads busy high out of reset since core 0 owns the bus first */
module dual_core_bus_top #(
    parameter int RUN_CYCLES  = 2,
    parameter int MEM_LATENCY = 3,
    parameter int MEM_AW      = 6
) (
    input  logic               CLK,
    input  logic               RST_X,
    input  logic               init_done,
    input  bus_pkg::addr_t     c0_paddr,
    input  logic               c0_we,
    input  logic               c0_le,
    input  bus_pkg::data_t     c0_wdata,
    input  bus_pkg::cpustate_t c0_cpustate,
    output bus_pkg::data_t     c0_rdata,
    output logic               c0_busy,
    input  bus_pkg::addr_t     c1_paddr,
    input  logic               c1_we,
    input  logic               c1_le,
    input  bus_pkg::data_t     c1_wdata,
    input  bus_pkg::cpustate_t c1_cpustate,
    output bus_pkg::data_t     c1_rdata,
    output logic               c1_busy,
    output bus_pkg::grant_t    grant
);

    core_bus_if core0_bus ();
    core_bus_if core1_bus ();
    mem_bus_if  mem_bus ();

    assign core0_bus.paddr    = c0_paddr;
    assign core0_bus.we       = c0_we;
    assign core0_bus.le       = c0_le;
    assign core0_bus.wdata    = c0_wdata;
    assign core0_bus.cpustate = c0_cpustate;
    assign c0_rdata           = core0_bus.rdata;
    assign c0_busy            = core0_bus.busy;

    assign core1_bus.paddr    = c1_paddr;
    assign core1_bus.we       = c1_we;
    assign core1_bus.le       = c1_le;
    assign core1_bus.wdata    = c1_wdata;
    assign core1_bus.cpustate = c1_cpustate;
    assign c1_rdata           = core1_bus.rdata;
    assign c1_busy            = core1_bus.busy;

    bus_arbiter_ser #(
        .RUN_CYCLES (RUN_CYCLES)
    ) u_bus_arbiter_ser (
        .CLK       (CLK),
        .RST_X     (RST_X),
        .init_done (init_done),
        .core0     (core0_bus.arb),
        .core1     (core1_bus.arb),
        .mem       (mem_bus.master),
        .grant     (grant)
    );

    shared_mem #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_AW      (MEM_AW)
    ) u_shared_mem (
        .CLK   (CLK),
        .RST_X (RST_X),
        .bus   (mem_bus.slave)
    );

endmodule

/* tb_dual_core_bus_sva.sv */
/* Assertions on the arbiter, bound into every bus_arbiter_ser instance.
   Checks are off while reset is asserted */
module tb_dual_core_bus_sva (
    input logic                CLK,
    input logic                RST_X,
    input bus_pkg::arb_state_t state,
    input bus_pkg::grant_t     grant,
    input logic                c0_busy,
    input logic                c1_busy,
    input bus_pkg::data_t      c0_rdata,
    input bus_pkg::data_t      c1_rdata
);
    import bus_pkg::*;

    // A new owner only appears on the edge that leaves arb_switch
    grant_only_after_switch: assert property (@(posedge CLK) disable iff (!RST_X)
        $changed(grant) |-> $past(state) == arb_switch)
        else $error("grant changed outside arb_switch");

    idle_core_busy: assert property (@(posedge CLK) disable iff (!RST_X)
        ((grant == 1'b0) ? c1_busy : c0_busy) == 1'b1)
        else $error("ungranted core saw busy low");

    idle_core_rdata: assert property (@(posedge CLK) disable iff (!RST_X)
        ((grant == 1'b0) ? c1_rdata : c0_rdata) == '0)
        else $error("ungranted core saw nonzero read data");

endmodule

bind bus_arbiter_ser tb_dual_core_bus_sva u_tb_dual_core_bus_sva (
    .CLK      (CLK),
    .RST_X    (RST_X),
    .state    (state),
    .grant    (grant_q),
    .c0_busy  (core0.busy),
    .c1_busy  (core1.busy),
    .c0_rdata (core0.rdata),
    .c1_rdata (core1.rdata)
);

/* tb_dual_core_bus.sv */
/* Table-driven testbench for the two-core bus. It runs with the default parameters
   and only loads words that the table has written before */
module tb_dual_core_bus;
    import bus_pkg::*;

    localparam int RUN_CYCLES      = 2;
    localparam int MEM_LATENCY     = 3;
    localparam int MEM_AW          = 6;
    localparam int NUM_ENTRIES     = 10;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * (MEM_LATENCY + RUN_CYCLES + 10) * 4;

    typedef struct packed {
        logic  core;
        logic  is_wr;
        addr_t addr;
        data_t wdata;
        data_t exp;
    } entry_t;

    logic      CLK;
    logic      RST_X;
    logic      init_done;
    addr_t     c0_paddr;
    logic      c0_we;
    logic      c0_le;
    data_t     c0_wdata;
    cpustate_t c0_cpustate;
    data_t     c0_rdata;
    logic      c0_busy;
    addr_t     c1_paddr;
    logic      c1_we;
    logic      c1_le;
    data_t     c1_wdata;
    cpustate_t c1_cpustate;
    data_t     c1_rdata;
    logic      c1_busy;
    grant_t    grant;

    entry_t table_q [NUM_ENTRIES];
    data_t  ref_mem [2**MEM_AW];

    dual_core_bus_top #(
        .RUN_CYCLES  (RUN_CYCLES),
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_AW      (MEM_AW)
    ) u_dual_core_bus_top (
        .CLK         (CLK),
        .RST_X       (RST_X),
        .init_done   (init_done),
        .c0_paddr    (c0_paddr),
        .c0_we       (c0_we),
        .c0_le       (c0_le),
        .c0_wdata    (c0_wdata),
        .c0_cpustate (c0_cpustate),
        .c0_rdata    (c0_rdata),
        .c0_busy     (c0_busy),
        .c1_paddr    (c1_paddr),
        .c1_we       (c1_we),
        .c1_le       (c1_le),
        .c1_wdata    (c1_wdata),
        .c1_cpustate (c1_cpustate),
        .c1_rdata    (c1_rdata),
        .c1_busy     (c1_busy),
        .grant       (grant)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        report_fail("timeout waiting for bus grant");
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            report_fail($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // The core without the grant must see a busy bus and zero data
    task automatic check_idle_side();
        if (grant == 1'b0) begin
            check_value("c1_busy", c1_busy, 32'h1);
            check_value("c1_rdata", c1_rdata, 32'h0);
        end else begin
            check_value("c0_busy", c0_busy, 32'h1);
            check_value("c0_rdata", c0_rdata, 32'h0);
        end
    endtask

    // Outputs are sampled one unit after the edge
    task automatic tick();
        @(posedge CLK);
        #1;
        check_idle_side();
    endtask

    function automatic logic busy_of(input logic core);
        return core ? c1_busy : c0_busy;
    endfunction

    task automatic set_entry(input int idx, input logic core, input logic is_wr,
                             input addr_t addr, input data_t wdata);
        table_q[idx].core  = core;
        table_q[idx].is_wr = is_wr;
        table_q[idx].addr  = addr;
        table_q[idx].wdata = wdata;
        if (is_wr) begin
            ref_mem[addr[MEM_AW-1:0]] = wdata;
        end
        table_q[idx].exp = ref_mem[addr[MEM_AW-1:0]];
    endtask

    task automatic set_states(input logic core);
        c0_cpustate = core ? cs_id : cs_ex;
        c1_cpustate = core ? cs_ex : cs_id;
    endtask

    task automatic drive_strobe(input entry_t e);
        if (e.core == 1'b0) begin
            c0_paddr = e.addr;
            c0_wdata = e.wdata;
            c0_we    = e.is_wr;
            c0_le    = !e.is_wr;
        end else begin
            c1_paddr = e.addr;
            c1_wdata = e.wdata;
            c1_we    = e.is_wr;
            c1_le    = !e.is_wr;
        end
    endtask

    initial begin
        entry_t e;
        int     n;
        void'($urandom(32'h86cb2e6a));
        RST_X       = 1'b0;
        init_done   = 1'b0;
        c0_paddr    = '0;
        c0_we       = 1'b0;
        c0_le       = 1'b0;
        c0_wdata    = '0;
        c0_cpustate = cs_ex;
        c1_paddr    = '0;
        c1_we       = 1'b0;
        c1_le       = 1'b0;
        c1_wdata    = '0;
        c1_cpustate = cs_ex;

        // Address 0x45 aliases word 5 in a 64-word memory
        set_entry(0, 1'b0, 1'b1, 32'h03, $urandom);
        set_entry(1, 1'b0, 1'b0, 32'h03, '0);
        set_entry(2, 1'b1, 1'b1, 32'h10, $urandom);
        set_entry(3, 1'b0, 1'b0, 32'h10, '0);
        set_entry(4, 1'b1, 1'b1, 32'h21, 32'ha5a5_5a5a);
        set_entry(5, 1'b1, 1'b0, 32'h21, '0);
        set_entry(6, 1'b0, 1'b1, 32'h45, $urandom);
        set_entry(7, 1'b1, 1'b0, 32'h05, '0);
        set_entry(8, 1'b0, 1'b1, 32'h03, $urandom);
        set_entry(9, 1'b1, 1'b0, 32'h03, '0);

        repeat (5) @(posedge CLK);
        #1;
        RST_X = 1'b1;
        tick();
        check_value("grant", grant, 32'h0);
        check_value("c1_busy", c1_busy, 32'h1);
        check_value("c0_busy", c0_busy, 32'h0);

        // Core 0 stays in cs_ex, so the slice must not end
        init_done   = 1'b1;
        c1_cpustate = cs_id;
        repeat (20) begin
            tick();
            check_value("grant", grant, 32'h0);
        end
        c0_cpustate = cs_id;
        tick();
        n = 1;
        while (grant === 1'b0) begin
            tick();
            n++;
        end
        check_value("grant_edges", n, 32'd2);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e = table_q[i];
            set_states(e.core);
            tick();
            while (grant !== e.core || busy_of(e.core) !== 1'b0) begin
                tick();
            end
            drive_strobe(e);
            tick();
            c0_we = 1'b0;
            c0_le = 1'b0;
            c1_we = 1'b0;
            c1_le = 1'b0;
            n = 0;
            while (busy_of(e.core) === 1'b1) begin
                n++;
                tick();
            end
            check_value("busy_cycles", n, MEM_LATENCY);
            if (!e.is_wr) begin
                check_value(e.core ? "c1_rdata" : "c0_rdata",
                            e.core ? c1_rdata : c0_rdata, e.exp);
            end
            if (e.core) begin
                c1_cpustate = cs_id;
            end else begin
                c0_cpustate = cs_id;
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* project.f */
bus_pkg.sv
core_bus_if.sv
mem_bus_if.sv
bus_arbiter_ser.sv
shared_mem.sv
dual_core_bus_top.sv
tb_dual_core_bus_sva.sv
tb_dual_core_bus.sv

/* Bender.yml */
package:
  name: dual_core_bus

sources:
  - bus_pkg.sv
  - core_bus_if.sv
  - mem_bus_if.sv
  - bus_arbiter_ser.sv
  - shared_mem.sv
  - dual_core_bus_top.sv
  - target: test
    files:
      - tb_dual_core_bus_sva.sv
      - tb_dual_core_bus.sv
